//--- all.f
+incdir+verilog
verilog/biosPkg.sv
verilog/biosCmdDecode.sv
verilog/biosScheduler.sv
verilog/quantumCounter.sv
verilog/millisTimer.sv
verilog/biosTop.sv
testbench/biosTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the bios supervisor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module biosTb \
	-Mdir obj_dir \
	-o biosSim \
	-f all.f

simStatus=0
simOut=$(./obj_dir/biosSim 2>&1) || simStatus=$?
echo "$simOut"

# the pass line decides, a nonzero exit status counts as failure too
if [ "$simStatus" -eq 0 ] && grep -q "Regression passed" <<< "$simOut"; then
	exit 0
fi
exit 1

//--- testbench/biosTb.sv
module biosTb;

	import biosPkg::*;

	// one row of the stimulus table
	typedef struct packed
	{
		biosOp_t opCode;
		biosWord_t info;
		logic doneInst;
		logic [7:0] hold; // cycles the row stays on the inputs
		biosState_t expState; // state after the last held edge
		biosWord_t expInfo;
		logic checkInfo; // compare biosInfo as well
	} stepRow_t;

	localparam int millisCycles = 10; // short ms so GETTIME moves quickly
	localparam biosOp_t nopCode = biosOp_t'(8'h00); // ordinary cpu instruction

	logic clk;
	logic rstN;
	biosOp_t opCode;
	biosWord_t info;
	logic doneInst;
	biosState_t state;
	logic control;
	biosWord_t biosInfo;

	stepRow_t steps[$];
	string stepName[$];
	integer seed;
	int q1; // slice length of the expiry test
	int q2; // slice length of the lock and halt tests
	int edgeCount; // rising edges since time 0
	int e0Edge; // edge that ends INV
	int cycleLimit;

	biosTop #(.millisCycles(millisCycles)) dut0
	(
		.clk(clk),
		.rstN(rstN),
		.opCode(opCode),
		.info(info),
		.doneInst(doneInst),
		.state(state),
		.control(control),
		.biosInfo(biosInfo)
	);

	always #4 clk = ~clk;

	// edge counter and watchdog
	always @(posedge clk)
	begin
		edgeCount <= edgeCount + 1;
		if (edgeCount >= cycleLimit)
		begin
			$display("timeout: stimulus table not finished after %0d cycles", cycleLimit);
			$display("Regression failed");
			$fatal(1, "simulation stopped by watchdog");
		end
	end

	task automatic compareValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %s: expected %0d, actual %0d", testName, expected, actual);
			$display("Regression failed");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic addStep(input string name, input biosOp_t op, input biosWord_t data,
		input logic done, input int hold, input biosState_t expSt, input biosWord_t expData,
		input logic chk);
		stepRow_t row;
		row.opCode = op;
		row.info = data;
		row.doneInst = done;
		row.hold = 8'(hold);
		row.expState = expSt;
		row.expInfo = expData;
		row.checkInfo = chk;
		steps.push_back(row);
		stepName.push_back(name);
		cycleLimit = cycleLimit + hold; // watchdog grows with the table
	endtask

	// GETTIME rows carry 0 and get their value at check time
	task automatic fillTable();
		// held into the second millisecond, first edge that reads back 1
		addStep("getTimeStart", GETTIME, 0, 1'b0, 11, BIOSEXEC, 0, 1'b1);
		addStep("setQuantum1", SETQUANTUM, q1, 1'b0, 1, BIOSEXEC, 0, 1'b0);
		addStep("biosIntNoDone", BIOSINT, 0, 1'b0, 2, BIOSEXEC, 0, 1'b0);
		addStep("biosIntNoDoneTail", nopCode, 0, 1'b0, 1, BIOSEXEC, 0, 1'b0); // last pulse dies
		addStep("biosIntStart", BIOSINT, 0, 1'b1, 1, BIOSEXEC, 0, 1'b0);
		addStep("enterProcess", nopCode, 0, 1'b1, 1, PROCESSEXEC, 0, 1'b0);
		addStep("sliceRun", nopCode, 0, 1'b0, q1, PROCESSEXEC, 0, 1'b0); // Q+1 cycles in all
		addStep("sliceExpire", nopCode, 0, 1'b0, 1, PROCESSINT, 0, 1'b0);
		addStep("intWaitGetTime", GETTIME, 0, 1'b0, 3, PROCESSINT, 0, 1'b1);
		addStep("getQuantumInt", GETQUANTUM, 0, 1'b0, 1, PROCESSINT, q1 + 4, 1'b1);
		addStep("intReturn", nopCode, 0, 1'b1, 1, BIOSEXEC, 0, 1'b0);

		// lock holds the slice past its limit
		addStep("setQuantum2", SETQUANTUM, q2, 1'b0, 1, BIOSEXEC, 0, 1'b0);
		addStep("lock", LOCK, 0, 1'b0, 1, BIOSEXEC, 0, 1'b0);
		addStep("biosInt2", BIOSINT, 0, 1'b1, 1, BIOSEXEC, 0, 1'b0);
		addStep("enterProcess2", nopCode, 0, 1'b1, 1, PROCESSEXEC, 0, 1'b0);
		addStep("lockedRun", nopCode, 0, 1'b0, q2 + 6, PROCESSEXEC, 0, 1'b0);
		addStep("getQuantumLocked", GETQUANTUM, 0, 1'b0, 1, PROCESSEXEC, q2 + 6, 1'b1);
		addStep("release", RELEASE, 0, 1'b0, 1, PROCESSEXEC, 0, 1'b0);
		addStep("releaseInt", nopCode, 0, 1'b0, 1, PROCESSINT, 0, 1'b0);
		addStep("intReturn2", nopCode, 0, 1'b1, 1, BIOSEXEC, 0, 1'b0);

		// halt gets through a held slice
		addStep("lock2", LOCK, 0, 1'b0, 1, BIOSEXEC, 0, 1'b0);
		addStep("biosInt3", BIOSINT, 0, 1'b1, 1, BIOSEXEC, 0, 1'b0);
		addStep("enterProcess3", nopCode, 0, 1'b1, 1, PROCESSEXEC, 0, 1'b0);
		addStep("lockedRun2", nopCode, 0, 1'b0, q2 + 3, PROCESSEXEC, 0, 1'b0);
		addStep("halt", HALT, 0, 1'b0, 1, PROCESSEXEC, 0, 1'b0);
		addStep("haltInt", nopCode, 0, 1'b0, 1, PROCESSINT, 0, 1'b0);
		addStep("intReturn3", nopCode, 0, 1'b1, 1, BIOSEXEC, 0, 1'b0);
		addStep("getQuantumBios", GETQUANTUM, 0, 1'b0, 2, BIOSEXEC, 0, 1'b1); // cleared
		addStep("releaseEnd", RELEASE, 0, 1'b0, 1, BIOSEXEC, 0, 1'b0);
		addStep("getTimeEnd", GETTIME, 0, 1'b0, 1, BIOSEXEC, 0, 1'b1);
	endtask

	// runs 1 unit after the last held edge when outputs have settled
	task automatic checkStep(input int idx);
		biosWord_t expected;
		expected = steps[idx].expInfo;
		if (steps[idx].opCode == GETTIME)
		begin
			// ms value held before the last sampling edge
			expected = (edgeCount - e0Edge - 1) / millisCycles;
		end
		compareValue({stepName[idx], " state"}, 32'(steps[idx].expState), 32'(state));
		compareValue({stepName[idx], " control"}, 32'(steps[idx].expState == BIOSEXEC),
			32'(control)); // high only in BIOSEXEC
		if (steps[idx].checkInfo)
		begin
			compareValue({stepName[idx], " biosInfo"}, expected, biosInfo);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		opCode = nopCode;
		info = '0;
		doneInst = 1'b0;
		edgeCount = 0;
		cycleLimit = 50; // margin for reset and init
		seed = 32'hf5ba_a1f0;

		// slice lengths 2 to 9
		q1 = 2 + ($unsigned($random(seed)) % 8);
		q2 = 2 + ($unsigned($random(seed)) % 8);
		fillTable();

		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;
		compareValue("resetState", 32'(INV), 32'(state));
		compareValue("resetControl", 32'd0, 32'(control));

		@(posedge clk); // e0 leaves INV
		#1;
		e0Edge = edgeCount;
		compareValue("initState", 32'(BIOSEXEC), 32'(state));
		compareValue("initControl", 32'd1, 32'(control));

		// drive and hold each row then check 1 unit after its last edge
		for (int i = 0; i < steps.size(); i++)
		begin
			opCode = steps[i].opCode;
			info = steps[i].info;
			doneInst = steps[i].doneInst;
			repeat (steps[i].hold) @(posedge clk);
			#1;
			checkStep(i);
		end

		$display("Regression passed");
		$finish;
	end

endmodule

//--- verilog/biosCmdDecode.sv
module biosCmdDecode
(
	input logic clk,
	input logic rstN,
	input biosPkg::biosOp_t opCode, // sampled every edge
	input biosPkg::biosWord_t info, // operand for SETQUANTUM
	input biosPkg::biosWord_t quantumCount, // current slice count
	input biosPkg::biosWord_t millisTime, // ms since init
	output biosPkg::cmdFlags_t cmdFlags,
	output biosPkg::biosWord_t quantumLimit,
	output biosPkg::biosWord_t biosInfo
);

	import biosPkg::*;

	// one register stage, every result shows up right after the sampling edge
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			cmdFlags <= '0;
			quantumLimit <= '0;
			biosInfo <= '0;
		end
		else
		begin
			// pulses default low, so each lasts one cycle
			cmdFlags.releaseExec <= 1'b0;
			cmdFlags.programDone <= 1'b0;

			case (opCode)
				LOCK:
				begin
					cmdFlags.lockQuantum <= 1'b1; // slice can't expire now
				end
				RELEASE:
				begin
					cmdFlags.lockQuantum <= 1'b0;
				end
				BIOSINT:
				begin
					cmdFlags.releaseExec <= 1'b1; // start user program
				end
				HALT:
				begin
					cmdFlags.programDone <= 1'b1; // user program finished
				end
				SETQUANTUM:
				begin
					quantumLimit <= info;
				end
				GETTIME:
				begin
					biosInfo <= millisTime;
				end
				GETQUANTUM:
				begin
					biosInfo <= quantumCount; // count as held at this edge
				end
				default:
				begin
					// ordinary cpu instruction, not for us
				end
			endcase
		end
	end

endmodule

//--- verilog/biosPkg.sv
package biosPkg;

	`include "bios_macros.svh"

	// supervisor states with a fixed 2-bit encoding
	typedef enum logic [1:0]
	{
		INV = 2'd0, // one cycle of init after reset
		BIOSEXEC = 2'd1, // bios owns the cpu
		PROCESSEXEC = 2'd2, // user program running
		PROCESSINT = 2'd3 // user program interrupted and waiting for cpu
	} biosState_t;

	// commands decoded from the processor opcode
	typedef enum logic [`BIOS_OP_WIDTH-1:0]
	{
		GETTIME = `BIOS_OP_GETTIME,
		LOCK = `BIOS_OP_LOCK,
		RELEASE = `BIOS_OP_RELEASE,
		GETQUANTUM = `BIOS_OP_GETQUANTUM,
		SETQUANTUM = `BIOS_OP_SETQUANTUM,
		BIOSINT = `BIOS_OP_BIOSINT,
		HALT = `BIOS_OP_HALT
	} biosOp_t;

	// data, info, slice and time words
	typedef logic [`BIOS_DATA_WIDTH-1:0] biosWord_t;

	// decoder to scheduler
	typedef struct packed
	{
		logic lockQuantum; // level set by LOCK and cleared by RELEASE
		logic releaseExec; // one cycle pulse from BIOSINT
		logic programDone; // one cycle pulse from HALT
	} cmdFlags_t;

endpackage

//--- verilog/biosScheduler.sv
module biosScheduler
(
	input logic clk,
	input logic rstN,
	input biosPkg::cmdFlags_t cmdFlags, // from decoder, one cycle behind opCode
	input logic doneInst, // cpu finished its current instruction
	input logic quantumExpired, // slice count reached the limit
	output biosPkg::biosState_t state,
	output logic control // high while bios owns the cpu
);

	import biosPkg::*;

	biosState_t nextState;

	// next state
	always_comb
	begin
		nextState = state; // hold by default

		case (state)
			INV:
			begin
				nextState = BIOSEXEC; // init lasts exactly one cycle
			end
			BIOSEXEC:
			begin
				// bios asked to run the user program and cpu is between instructions
				if (cmdFlags.releaseExec && doneInst)
				begin
					nextState = PROCESSEXEC;
				end
			end
			PROCESSEXEC:
			begin
				if (cmdFlags.programDone)
				begin
					nextState = PROCESSINT; // halt wins even when locked
				end
				else if (quantumExpired && !cmdFlags.lockQuantum)
				begin
					nextState = PROCESSINT; // slice used up
				end
			end
			PROCESSINT:
			begin
				// wait for the cpu to finish the instruction in flight
				if (doneInst)
				begin
					nextState = BIOSEXEC;
				end
			end
			default:
			begin
				nextState = INV;
			end
		endcase
	end

	// state and control move together
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= INV;
			control <= 1'b0;
		end
		else
		begin
			state <= nextState;
			control <= (nextState == BIOSEXEC); // follows the new state, no lag
		end
	end

endmodule

//--- verilog/biosTop.sv
`include "bios_macros.svh"

module biosTop
#(
	parameter int millisCycles = `BIOS_MILLIS_CYCLES
)
(
	input logic clk,
	input logic rstN,
	input biosPkg::biosOp_t opCode, // from processor
	input biosPkg::biosWord_t info, // data word from processor
	input logic doneInst,
	output biosPkg::biosState_t state,
	output logic control,
	output biosPkg::biosWord_t biosInfo // answer to GETTIME / GETQUANTUM
);

	import biosPkg::*;

	cmdFlags_t cmdFlags; // decoder to scheduler
	biosWord_t quantumLimit;
	biosWord_t quantumCount;
	biosWord_t millisTime;
	logic quantumExpired;

	biosCmdDecode decode0
	(
		.clk(clk),
		.rstN(rstN),
		.opCode(opCode),
		.info(info),
		.quantumCount(quantumCount),
		.millisTime(millisTime),
		.cmdFlags(cmdFlags),
		.quantumLimit(quantumLimit),
		.biosInfo(biosInfo)
	);

	// the only control block, everything else is datapath around it
	biosScheduler sched0
	(
		.clk(clk),
		.rstN(rstN),
		.cmdFlags(cmdFlags),
		.doneInst(doneInst),
		.quantumExpired(quantumExpired),
		.state(state),
		.control(control)
	);

	quantumCounter quantum0
	(
		.clk(clk),
		.rstN(rstN),
		.state(state),
		.quantumLimit(quantumLimit),
		.quantumCount(quantumCount),
		.quantumExpired(quantumExpired)
	);

	millisTimer #(.millisCycles(millisCycles)) timer0
	(
		.clk(clk),
		.rstN(rstN),
		.state(state),
		.millisTime(millisTime)
	);

endmodule

//--- verilog/bios_macros.svh
`ifndef BIOS_MACROS_SVH
`define BIOS_MACROS_SVH

// widths seen by the processor side
`define BIOS_OP_WIDTH 8
`define BIOS_DATA_WIDTH 32

// clock cycles per millisecond tick, 50 MHz board clock
`define BIOS_MILLIS_CYCLES 50000

// supervisor opcodes, upper nibble 4'hb marks a bios call
`define BIOS_OP_GETTIME 8'b1011_0000 // read millisecond timer
`define BIOS_OP_LOCK 8'b1011_0001 // hold the time slice
`define BIOS_OP_RELEASE 8'b1011_0010 // free the time slice
`define BIOS_OP_GETQUANTUM 8'b1011_0011 // read slice count
`define BIOS_OP_SETQUANTUM 8'b1011_0100 // load slice length
`define BIOS_OP_BIOSINT 8'b1011_0101 // hand cpu to user program

// halt sits outside the bios block, it is a plain cpu instruction
`define BIOS_OP_HALT 8'b0000_0001

`endif

//--- verilog/millisTimer.sv
`include "bios_macros.svh"

module millisTimer
#(
	parameter int millisCycles = `BIOS_MILLIS_CYCLES // clock cycles per ms
)
(
	input logic clk,
	input logic rstN,
	input biosPkg::biosState_t state,
	output biosPkg::biosWord_t millisTime // ms since INV ended
);

	import biosPkg::*;

	// prescaler needs at least one bit, even for a divisor of 1
	localparam int preWidth = (millisCycles > 1) ? $clog2(millisCycles) : 1;
	localparam logic [preWidth-1:0] preLast = preWidth'(millisCycles - 1);

	logic [preWidth-1:0] prescaler;
	logic msTick; // last cycle of a millisecond

	assign msTick = (prescaler == preLast);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			prescaler <= '0;
			millisTime <= '0;
		end
		else if (state == INV)
		begin
			// both held until init is over
			prescaler <= '0;
			millisTime <= '0;
		end
		else if (msTick)
		begin
			prescaler <= '0; // wrap
			millisTime <= millisTime + 1'b1;
		end
		else
		begin
			prescaler <= prescaler + 1'b1;
		end
	end

endmodule

//--- verilog/quantumCounter.sv
module quantumCounter
(
	input logic clk,
	input logic rstN,
	input biosPkg::biosState_t state,
	input biosPkg::biosWord_t quantumLimit, // loaded by SETQUANTUM
	output biosPkg::biosWord_t quantumCount,
	output logic quantumExpired
);

	import biosPkg::*;

	logic userSlice; // user program owns the slice
	logic countFull; // stop at all ones

	assign userSlice = (state == PROCESSEXEC) || (state == PROCESSINT);
	assign countFull = &quantumCount;

	// cycles since the slice began
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			quantumCount <= '0;
		end
		else if (!userSlice)
		begin
			quantumCount <= '0; // INV and BIOSEXEC clear between slices
		end
		else if (!countFull)
		begin
			quantumCount <= quantumCount + 1'b1;
		end
	end

	// count starts at 0 on entry, so PROCESSEXEC lasts quantumLimit+1 cycles
	assign quantumExpired = (quantumCount >= quantumLimit);

endmodule
